/* verilog/tk2000_pkg.sv */
// ==============================
// Shared types and constants for the TK2000 board glue logic.
// Every glue module imports this package for its buses and enums.
// ==============================
`default_nettype none

package tk2000_pkg;

	typedef logic [7:0]  byte_t;
	typedef logic [5:0]  track_num_t;
	typedef logic [3:0]  sector_t;
	typedef logic [8:0]  buf_addr_t;
	// Sector index then byte position, with one spare top bit
	typedef logic [13:0] track_addr_t;
	typedef logic [31:0] lba_t;
	typedef logic [15:0] ram_addr_t;

	typedef struct packed {
		ram_addr_t addr;
		byte_t     data;
		logic      we;
	} ram_req_t;

	// Joystick switches, active high
	typedef struct packed {
		logic right;
		logic left;
		logic down;
		logic up;
		logic fire1;
		logic fire2;
	} joy_t;

	typedef struct packed {
		logic rd;
		logic wr;
		lba_t lba;
	} sd_req_t;

	// Host side buffer write port, shared by both drives
	typedef struct packed {
		buf_addr_t addr;
		byte_t     data;
		logic      wr;
	} sd_buf_t;

	typedef struct packed {
		track_addr_t addr;
		logic        write;
		byte_t       data;
	} fd_port_t;

	typedef enum logic [1:0] {
		LD_IDLE,
		LD_WRITE_BACK,
		LD_START_READ,
		LD_READ
	} loader_state_e;

	typedef struct packed {
		logic user_button;
		logic menu_reset;
		logic pump_active;
	} reset_req_t;

	localparam int        SECTORS_PER_TRACK = 13;
	localparam sector_t   LAST_SECTOR       = 4'd12;
	// Location zeroed while the machine sits in power-on reset
	localparam ram_addr_t RAM_CLEAR_ADDR    = 16'h03F4;
	localparam int        JOY_COL_DIR       = 0;
	localparam int        JOY_COL_FIRE      = 4;

endpackage

`default_nettype wire

/* verilog/reset_sequencer.sv */
// ==============================
// Power-on and reset sequencer.
// Counts out the power-on delay after the last reset request and
// forces a zero write to one RAM location while reset is held.
// ==============================
`timescale 1ns/1ps
`default_nettype none

module reset_sequencer #(
	parameter int POR_BITS = 23
) (
	input  wire logic                   CLK_VIDEO,
	input  wire logic                   dd_reset,
	input  wire tk2000_pkg::reset_req_t reset_req_i,
	input  wire tk2000_pkg::ram_req_t   ram_cpu_i,
	output logic                        por_o,
	output logic                        cpu_reset_o,
	output tk2000_pkg::ram_req_t        ram_o
);
	import tk2000_pkg::*;

	logic [POR_BITS-1:0] por_cnt;
	logic                any_req;

	assign any_req = reset_req_i.user_button | reset_req_i.menu_reset |
		reset_req_i.pump_active;

	// ==============================
	// Delay counter, stands in for the old 555 timer
	// ==============================
	always_ff @(posedge CLK_VIDEO) begin
		if (dd_reset) begin
			por_cnt     <= '0;
			por_o       <= 1'b1;
			cpu_reset_o <= 1'b1;
		end else begin
			cpu_reset_o <= por_o | any_req;
			if (any_req) begin
				por_cnt <= '0;
				por_o   <= 1'b1;
			end else if (por_o) begin
				// Release once the top bit has been seen set
				if (por_cnt[POR_BITS-1])
					por_o <= 1'b0;
				por_cnt <= por_cnt + 1'b1;
			end
		end
	end

	// Clear write overrides the CPU port while in reset
	always_comb begin
		if (por_o) begin
			ram_o.addr = RAM_CLEAR_ADDR;
			ram_o.data = '0;
			ram_o.we   = 1'b1;
		end else begin
			ram_o = ram_cpu_i;
		end
	end

	// A request holds the sequencer and reaches the CPU reset a cycle later
	a_req_holds_reset: assert property (@(posedge CLK_VIDEO) disable iff (dd_reset)
		any_req |=> por_o ##1 cpu_reset_o);

endmodule

`default_nettype wire

/* verilog/joy_kbd_merge.sv */
// ==============================
// Joystick to keyboard merge.
// Joystick switches show up as key presses on two column lines
// when the CPU scans the matching rows.
// ==============================
`timescale 1ns/1ps
`default_nettype none

module joy_kbd_merge (
	input  wire logic             CLK_VIDEO,
	input  wire logic             dd_reset,
	input  wire tk2000_pkg::joy_t joy_i,
	input  wire logic [7:0]       kbd_rows_i,
	input  wire logic [5:0]       kbd_cols_i,
	output logic [5:0]            kbd_cols_o
);
	import tk2000_pkg::*;

	logic       dir_hit;
	logic       fire_hit;
	logic [5:0] cols_next;

	// Direction switches share one column across four rows
	assign dir_hit = (kbd_rows_i[6] & joy_i.up) | (kbd_rows_i[5] & joy_i.down) |
		(kbd_rows_i[4] & joy_i.right) | (kbd_rows_i[3] & joy_i.left);
	assign fire_hit = (kbd_rows_i[7] & joy_i.fire1) | (kbd_rows_i[6] & joy_i.fire2);

	always_comb begin
		cols_next               = kbd_cols_i;
		cols_next[JOY_COL_DIR]  = kbd_cols_i[JOY_COL_DIR] | dir_hit;
		cols_next[JOY_COL_FIRE] = kbd_cols_i[JOY_COL_FIRE] | fire_hit;
	end

	always_ff @(posedge CLK_VIDEO) begin
		if (dd_reset)
			kbd_cols_o <= '0;
		else
			kbd_cols_o <= cols_next;
	end

endmodule

`default_nettype wire

/* verilog/track_buffer.sv */
// ==============================
// Track memory for one floppy drive.
// Port A is filled and drained by the SD host, port B serves the
// disk controller. Both reads are registered.
// ==============================
`timescale 1ns/1ps
`default_nettype none

module track_buffer (
	input  wire logic                    CLK_VIDEO,
	input  wire tk2000_pkg::track_addr_t host_addr_i,
	input  wire logic                    host_we_i,
	input  wire tk2000_pkg::byte_t       host_data_i,
	input  wire tk2000_pkg::fd_port_t    disk_i,
	output tk2000_pkg::byte_t            host_q_o,
	output tk2000_pkg::byte_t            disk_q_o
);
	import tk2000_pkg::*;

	localparam int DEPTH = 1 << $bits(track_addr_t);

	byte_t mem [DEPTH];

	// ==============================
	// Dual port access
	// ==============================
	always_ff @(posedge CLK_VIDEO) begin
		if (host_we_i)
			mem[host_addr_i] <= host_data_i;
		// Controller write lands last on an address clash
		if (disk_i.write)
			mem[disk_i.addr] <= disk_i.data;
	end

	// Read before write on both ports
	always_ff @(posedge CLK_VIDEO) begin
		host_q_o <= mem[host_addr_i];
		disk_q_o <= mem[disk_i.addr];
	end

endmodule

`default_nettype wire

/* verilog/track_loader.sv */
// ==============================
// Track loader for one floppy drive.
// Streams a 13 sector track from the SD image into the track buffer
// and writes a modified track back before moving to another one.
// ==============================
`timescale 1ns/1ps
`default_nettype none

module track_loader (
	input  wire logic                   CLK_VIDEO,
	input  wire logic                   dd_reset,
	input  wire tk2000_pkg::track_num_t track_i,
	input  wire logic                   img_mounted_i,
	input  wire logic [63:0]            img_size_i,
	input  wire logic                   sd_ack_i,
	input  wire logic                   disk_write_i,
	output tk2000_pkg::sd_req_t         sd_req_o,
	output tk2000_pkg::sector_t         sector_o,
	output logic                        cpu_wait_o
);
	import tk2000_pkg::*;

	loader_state_e state_q;
	sd_req_t       req_q;
	sector_t       sector_q;
	track_num_t    cur_track_q;
	logic          ack_q;
	logic          ack_rise;
	logic          ack_fall;
	logic          disk_present_q;
	logic          mount_pend_q;
	logic          dirty_q;
	logic          cpu_wait_q;

	// First block of a track in the image
	function automatic lba_t track_lba(input track_num_t trk);
		return lba_t'(SECTORS_PER_TRACK) * lba_t'(trk);
	endfunction

	assign ack_rise = sd_ack_i & ~ack_q;
	assign ack_fall = ~sd_ack_i & ack_q;

	always_ff @(posedge CLK_VIDEO) begin
		if (dd_reset) begin
			state_q        <= LD_IDLE;
			req_q          <= '0;
			sector_q       <= '0;
			cur_track_q    <= '0;
			ack_q          <= 1'b0;
			disk_present_q <= 1'b0;
			mount_pend_q   <= 1'b0;
			dirty_q        <= 1'b0;
			cpu_wait_q     <= 1'b0;
		end else begin
			ack_q <= sd_ack_i;
			case (state_q)
				// Wait for a head move or a fresh image
				LD_IDLE: begin
					if ((cur_track_q != track_i) || mount_pend_q) begin
						mount_pend_q <= 1'b0;
						if (disk_present_q) begin
							sector_q <= '0;
							if (dirty_q) begin
								dirty_q   <= 1'b0;
								req_q.lba <= track_lba(cur_track_q);
								req_q.wr  <= 1'b1;
								state_q   <= LD_WRITE_BACK;
							end else begin
								state_q <= LD_START_READ;
							end
						end
					end
				end
				LD_WRITE_BACK: begin
					cpu_wait_q <= 1'b1;
					if (ack_rise) begin
						if (sector_q >= LAST_SECTOR)
							req_q.wr <= 1'b0;
						req_q.lba <= req_q.lba + 1'b1;
					end else if (ack_fall) begin
						sector_q <= sector_q + 1'b1;
						if (!req_q.wr)
							state_q <= LD_START_READ;
					end
				end
				LD_START_READ: begin
					cur_track_q <= track_i;
					sector_q    <= '0;
					req_q.lba   <= track_lba(track_i);
					req_q.rd    <= 1'b1;
					cpu_wait_q  <= 1'b1;
					state_q     <= LD_READ;
				end
				LD_READ: begin
					if (ack_rise) begin
						if (sector_q >= LAST_SECTOR)
							req_q.rd <= 1'b0;
						req_q.lba <= req_q.lba + 1'b1;
					end else if (ack_fall) begin
						sector_q <= sector_q + 1'b1;
						// Track complete, let the CPU run again
						if (!req_q.rd) begin
							cpu_wait_q <= 1'b0;
							state_q    <= LD_IDLE;
						end
					end
				end
				default: state_q <= LD_IDLE;
			endcase

			// New mount or controller write wins over a clear above
			if (img_mounted_i) begin
				disk_present_q <= |img_size_i;
				mount_pend_q   <= 1'b1;
			end
			if (disk_write_i)
				dirty_q <= 1'b1;
		end
	end

	assign sd_req_o   = req_q;
	assign sector_o   = sector_q;
	assign cpu_wait_o = cpu_wait_q;

	a_rd_wr_exclusive: assert property (@(posedge CLK_VIDEO) disable iff (dd_reset)
		!(req_q.rd && req_q.wr));

endmodule

`default_nettype wire

/* verilog/floppy_subsystem.sv */
// ==============================
// Two drive floppy block.
// One loader and one track buffer per drive, plus the controller
// read mux and the shared wait and LED outputs.
// ==============================
`timescale 1ns/1ps
`default_nettype none

module floppy_subsystem (
	input  wire logic                         CLK_VIDEO,
	input  wire logic                         dd_reset,
	input  wire tk2000_pkg::track_num_t [1:0] track_i,
	input  wire logic [1:0]                   drive_active_i,
	input  wire logic [1:0]                   img_mounted_i,
	input  wire logic [63:0]                  img_size_i,
	input  wire logic [1:0]                   sd_ack_i,
	input  wire tk2000_pkg::sd_buf_t          sd_buf_i,
	input  wire tk2000_pkg::fd_port_t         fd_i,
	output wire tk2000_pkg::sd_req_t [1:0]    sd_req_o,
	output wire tk2000_pkg::byte_t [1:0]      sd_buf_din_o,
	output tk2000_pkg::byte_t                 fd_data_o,
	output logic                              cpu_wait_o,
	output logic                              led_o
);
	import tk2000_pkg::*;

	logic [1:0]              drive_sel;
	wire logic [1:0]         wait_d;
	wire sector_t [1:0]      sector_d;
	wire byte_t [1:0]        disk_q_d;
	fd_port_t [1:0]          disk_port;
	track_addr_t [1:0]       host_addr;

	// Drive 0 has priority when both claim the bus
	assign drive_sel[0] = drive_active_i[0];
	assign drive_sel[1] = drive_active_i[1] & ~drive_active_i[0];

	for (genvar i = 0; i < 2; i++) begin : g_drive
		// Sector index above the byte position, spare top bit zero
		assign host_addr[i] = {1'b0, sector_d[i], sd_buf_i.addr};
		assign disk_port[i] = '{addr: fd_i.addr, write: fd_i.write & drive_sel[i],
			data: fd_i.data};

		track_loader u_track_loader (
			.CLK_VIDEO     (CLK_VIDEO),
			.dd_reset      (dd_reset),
			.track_i       (track_i[i]),
			.img_mounted_i (img_mounted_i[i]),
			.img_size_i    (img_size_i),
			.sd_ack_i      (sd_ack_i[i]),
			.disk_write_i  (disk_port[i].write),
			.sd_req_o      (sd_req_o[i]),
			.sector_o      (sector_d[i]),
			.cpu_wait_o    (wait_d[i])
		);

		track_buffer u_track_buffer (
			.CLK_VIDEO   (CLK_VIDEO),
			.host_addr_i (host_addr[i]),
			.host_we_i   (sd_buf_i.wr & sd_ack_i[i]),
			.host_data_i (sd_buf_i.data),
			.disk_i      (disk_port[i]),
			.host_q_o    (sd_buf_din_o[i]),
			.disk_q_o    (disk_q_d[i])
		);
	end

	// ==============================
	// Controller side outputs
	// ==============================
	always_comb begin
		if (drive_active_i[0])
			fd_data_o = disk_q_d[0];
		else if (drive_active_i[1])
			fd_data_o = disk_q_d[1];
		else
			fd_data_o = '0;
	end

	assign cpu_wait_o = |wait_d;
	assign led_o      = |drive_active_i;

endmodule

`default_nettype wire

/* verilog/tk2000_glue_top.sv */
// ==============================
// Board glue around the TK2000 core.
// Reset sequencing, joystick merge and the two drive floppy loader,
// all running on the video clock.
// ==============================
`timescale 1ns/1ps
`default_nettype none

module tk2000_glue_top #(
	parameter int POR_BITS = 23
) (
	input  wire logic                         CLK_VIDEO,
	input  wire logic                         dd_reset,
	// Reset and RAM
	input  wire tk2000_pkg::reset_req_t       reset_req_i,
	output wire logic                         cpu_reset_o,
	output wire logic                         por_o,
	input  wire tk2000_pkg::ram_req_t         ram_cpu_i,
	output wire tk2000_pkg::ram_req_t         ram_o,
	// Keyboard and joystick
	input  wire tk2000_pkg::joy_t             joy_i,
	input  wire logic [7:0]                   kbd_rows_i,
	input  wire logic [5:0]                   kbd_cols_i,
	output wire logic [5:0]                   kbd_cols_o,
	// SD host
	input  wire logic [1:0]                   sd_ack_i,
	input  wire tk2000_pkg::sd_buf_t          sd_buf_i,
	input  wire logic [1:0]                   img_mounted_i,
	input  wire logic [63:0]                  img_size_i,
	output wire tk2000_pkg::sd_req_t [1:0]    sd_req_o,
	output wire tk2000_pkg::byte_t [1:0]      sd_buf_din_o,
	// Disk controller
	input  wire tk2000_pkg::track_num_t [1:0] track_i,
	input  wire logic [1:0]                   drive_active_i,
	input  wire tk2000_pkg::fd_port_t         fd_i,
	output wire tk2000_pkg::byte_t            fd_data_o,
	output wire logic                         cpu_wait_o,
	output wire logic                         led_o
);

	reset_sequencer #(
		.POR_BITS (POR_BITS)
	) u_reset_sequencer (
		.CLK_VIDEO   (CLK_VIDEO),
		.dd_reset    (dd_reset),
		.reset_req_i (reset_req_i),
		.ram_cpu_i   (ram_cpu_i),
		.por_o       (por_o),
		.cpu_reset_o (cpu_reset_o),
		.ram_o       (ram_o)
	);

	joy_kbd_merge u_joy_kbd_merge (
		.CLK_VIDEO  (CLK_VIDEO),
		.dd_reset   (dd_reset),
		.joy_i      (joy_i),
		.kbd_rows_i (kbd_rows_i),
		.kbd_cols_i (kbd_cols_i),
		.kbd_cols_o (kbd_cols_o)
	);

	floppy_subsystem u_floppy_subsystem (
		.CLK_VIDEO      (CLK_VIDEO),
		.dd_reset       (dd_reset),
		.track_i        (track_i),
		.drive_active_i (drive_active_i),
		.img_mounted_i  (img_mounted_i),
		.img_size_i     (img_size_i),
		.sd_ack_i       (sd_ack_i),
		.sd_buf_i       (sd_buf_i),
		.fd_i           (fd_i),
		.sd_req_o       (sd_req_o),
		.sd_buf_din_o   (sd_buf_din_o),
		.fd_data_o      (fd_data_o),
		.cpu_wait_o     (cpu_wait_o),
		.led_o          (led_o)
	);

endmodule

`default_nettype wire

/* testbench/tb_tk2000_glue.sv */
// ==============================
// Testbench for the TK2000 board glue.
// Drives reset, joystick and floppy traffic into the top level,
// models the SD host and checks results against reference functions.
// ==============================
`timescale 1ns/1ps
`default_nettype none

module tb_tk2000_glue;
	import tk2000_pkg::*;

	localparam int          POR_BITS    = 6;
	localparam int          POR_DELAY   = 2 ** (POR_BITS - 1) + 1;
	localparam logic [31:0] SEED        = 32'h1ede_5bd2;
	localparam logic [15:0] CLEAR_ADDR  = 16'h03F4;
	localparam int          SECTORS     = 13;
	localparam int          N_WRITES    = 8;
	// Three track transfers of about 7000 cycles each plus the short tests
	localparam int          CYCLE_LIMIT = 200_000;

	logic                 CLK_VIDEO = 1'b0;
	logic                 dd_reset;
	reset_req_t           reset_req_i;
	ram_req_t             ram_cpu_i;
	joy_t                 joy_i;
	logic [7:0]           kbd_rows_i;
	logic [5:0]           kbd_cols_i;
	logic [1:0]           sd_ack_i;
	sd_buf_t              sd_buf_i;
	logic [1:0]           img_mounted_i;
	logic [63:0]          img_size_i;
	track_num_t [1:0]     track_i;
	logic [1:0]           drive_active_i;
	fd_port_t             fd_i;
	wire logic            cpu_reset_o;
	wire logic            por_o;
	wire ram_req_t        ram_o;
	wire logic [5:0]      kbd_cols_o;
	wire sd_req_t [1:0]   sd_req_o;
	wire byte_t [1:0]     sd_buf_din_o;
	wire byte_t           fd_data_o;
	wire logic            cpu_wait_o;
	wire logic            led_o;

	logic [31:0] rng = SEED;
	int          cycle_cnt = 0;
	sd_req_t     host_log[$];
	int          drive1_reqs = 0;
	byte_t       cap_mem [SECTORS * 512];
	int          wr_sec [N_WRITES];
	int          wr_pos [N_WRITES];
	byte_t       wr_val [N_WRITES];

	tk2000_glue_top #(
		.POR_BITS (POR_BITS)
	) u_tk2000_glue_top (.*);

	always #20 CLK_VIDEO = ~CLK_VIDEO;

	always @(posedge CLK_VIDEO) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT)
			abort_run("timeout: the tests did not finish within the cycle limit");
	end

	// ==============================
	// Reference functions
	// ==============================
	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_rand();
		rng = xorshift32(rng);
		return rng;
	endfunction

	// Disk image contents mixed from block number and byte position
	function automatic byte_t img_byte(input lba_t lba, input int pos);
		logic [31:0] x;
		x = xorshift32({lba[22:0], pos[8:0]} ^ 32'h5a5a_0f0f);
		return x[7:0] ^ x[23:16];
	endfunction

	function automatic logic por_expected(input int since_req);
		return since_req < POR_DELAY;
	endfunction

	function automatic logic [5:0] merge_ref(input logic [7:0] rows, input logic [5:0] cols,
		input joy_t j);
		logic [5:0] c;
		c = cols;
		if ((rows[6] && j.up) || (rows[5] && j.down) || (rows[4] && j.right) ||
			(rows[3] && j.left))
			c[0] = 1'b1;
		if ((rows[7] && j.fire1) || (rows[6] && j.fire2))
			c[4] = 1'b1;
		return c;
	endfunction

	// Old track contents with the controller writes laid over them
	function automatic byte_t written_track(input track_num_t trk, input int s, input int p);
		byte_t v;
		v = img_byte(lba_t'(SECTORS * trk + s), p);
		for (int i = 0; i < N_WRITES; i++)
			if (wr_sec[i] == s && wr_pos[i] == p)
				v = wr_val[i];
		return v;
	endfunction

	function automatic track_addr_t disk_addr(input int s, input int p);
		return {1'b0, 4'(s), 9'(p)};
	endfunction

	// ==============================
	// Compare tasks
	// ==============================
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Simulation finished: FAIL");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			abort_run($sformatf("mismatch at %0t ns: %s got %b expected %b",
				$time, name, got, exp));
	endtask

	task automatic check_ram(input string name, input ram_req_t got, input ram_req_t exp);
		if (got !== exp)
			abort_run($sformatf("mismatch at %0t ns: %s got %h expected %h",
				$time, name, got, exp));
	endtask

	task automatic check_byte(input string name, input byte_t got, input byte_t exp);
		if (got !== exp)
			abort_run($sformatf("mismatch at %0t ns: %s got %h expected %h",
				$time, name, got, exp));
	endtask

	task automatic check_sd_req(input string name, input sd_req_t got, input sd_req_t exp);
		if (got !== exp)
			abort_run($sformatf("mismatch at %0t ns: %s got rd=%b wr=%b lba=%0d %s",
				$time, name, got.rd, got.wr, got.lba,
				$sformatf("expected rd=%b wr=%b lba=%0d", exp.rd, exp.wr, exp.lba)));
	endtask

	task automatic check_cols(input string name, input logic [5:0] got, input logic [5:0] exp);
		if (got !== exp)
			abort_run($sformatf("mismatch at %0t ns: %s got %b expected %b",
				$time, name, got, exp));
	endtask

	task automatic check_log_size(input int n);
		if (host_log.size() != n)
			abort_run($sformatf("SD host served %0d sectors on drive 0 where %0d were due",
				host_log.size(), n));
	endtask

	task automatic expect_transfers(input int first, input logic is_write, input track_num_t trk);
		sd_req_t exp;
		for (int k = 0; k < SECTORS; k++) begin
			exp.rd  = ~is_write;
			exp.wr  = is_write;
			exp.lba = lba_t'(SECTORS * trk + k);
			check_sd_req("sd_req_o[0]", host_log[first + k], exp);
		end
	endtask

	// ==============================
	// Stimulus helpers
	// ==============================
	task automatic wait_track_load();
		while (cpu_wait_o !== 1'b1)
			@(negedge CLK_VIDEO);
		while (cpu_wait_o !== 1'b0)
			@(negedge CLK_VIDEO);
	endtask

	task automatic write_disk(input int s, input int p, input byte_t d);
		@(posedge CLK_VIDEO);
		fd_i <= '{addr: disk_addr(s, p), write: 1'b1, data: d};
		@(posedge CLK_VIDEO);
		fd_i <= '{addr: disk_addr(s, p), write: 1'b0, data: d};
	endtask

	task automatic read_disk(input int s, input int p, input byte_t exp);
		@(posedge CLK_VIDEO);
		fd_i <= '{addr: disk_addr(s, p), write: 1'b0, data: 8'h00};
		@(posedge CLK_VIDEO);
		@(negedge CLK_VIDEO);
		check_byte("fd_data_o", fd_data_o, exp);
	endtask

	// ==============================
	// SD host model
	// ==============================
	initial begin : sd_host
		sd_req_t     req;
		int          drv;
		logic [31:0] host_rng;
		sd_ack_i = '0;
		sd_buf_i = '0;
		host_rng = SEED ^ 32'h0000_ffff;
		forever begin
			@(negedge CLK_VIDEO);
			drv = -1;
			if (!dd_reset && (sd_req_o[0].rd || sd_req_o[0].wr))
				drv = 0;
			else if (!dd_reset && (sd_req_o[1].rd || sd_req_o[1].wr))
				drv = 1;
			if (drv >= 0) begin
				req = sd_req_o[drv];
				if (drv == 0)
					host_log.push_back(req);
				else
					drive1_reqs++;
				host_rng = xorshift32(host_rng);
				repeat (host_rng[1:0]) @(posedge CLK_VIDEO);
				@(posedge CLK_VIDEO);
				sd_ack_i[drv] <= 1'b1;
				// Buffer reads come back one cycle after the address
				for (int b = 0; b <= 512; b++) begin
					if (b > 0)
						@(posedge CLK_VIDEO);
					if (b < 512) begin
						sd_buf_i <= '{addr: buf_addr_t'(b), data: img_byte(req.lba, b),
							wr: req.rd};
					end else begin
						sd_buf_i      <= '0;
						sd_ack_i[drv] <= 1'b0;
					end
					@(negedge CLK_VIDEO);
					// CPU stays stalled for the whole transfer
					check_bit("cpu_wait_o", cpu_wait_o, 1'b1);
					if (req.wr && b > 0)
						cap_mem[(req.lba % SECTORS) * 512 + b - 1] = sd_buf_din_o[drv];
				end
			end
		end
	end

	// ==============================
	// Test sequence
	// ==============================
	initial begin : main_seq
		logic [31:0] rnd;
		int          hold;
		ram_req_t    ram_now;
		ram_req_t    ram_exp;
		logic [7:0]  prev_rows;
		logic [5:0]  prev_cols;
		joy_t        prev_joy;
		track_num_t  trk_a;
		track_num_t  trk_b;
		int          sec;
		int          pos;
		byte_t       val;
		dd_reset       = 1'b1;
		reset_req_i    = '0;
		ram_cpu_i      = '0;
		joy_i          = '0;
		kbd_rows_i     = '0;
		// All ones so that only the reset can clear the column register
		kbd_cols_i     = '1;
		img_mounted_i  = '0;
		img_size_i     = '0;
		track_i        = '0;
		drive_active_i = '0;
		fd_i           = '0;
		repeat (4) @(posedge CLK_VIDEO);
		dd_reset <= 1'b0;
		@(negedge CLK_VIDEO);
		check_bit("por_o", por_o, 1'b1);
		check_cols("kbd_cols_o", kbd_cols_o, 6'd0);

		// Reset requests restart the power-on delay
		for (int round = 0; round < 2; round++) begin
			hold = 1 + next_rand() % 4;
			@(posedge CLK_VIDEO);
			reset_req_i <= reset_req_t'(3'(next_rand() % 7 + 1));
			repeat (hold) @(posedge CLK_VIDEO);
			reset_req_i <= '0;
			@(negedge CLK_VIDEO);
			check_bit("por_o", por_o, 1'b1);
			check_bit("cpu_reset_o", cpu_reset_o, 1'b1);
			for (int k = 1; k <= POR_DELAY + 8; k++) begin
				@(posedge CLK_VIDEO);
				ram_now   = ram_req_t'(next_rand());
				ram_cpu_i <= ram_now;
				@(negedge CLK_VIDEO);
				if (por_expected(k))
					ram_exp = '{addr: CLEAR_ADDR, data: 8'h00, we: 1'b1};
				else
					ram_exp = ram_now;
				check_bit("por_o", por_o, por_expected(k));
				check_bit("cpu_reset_o", cpu_reset_o, por_expected(k - 1));
				check_ram("ram_o", ram_o, ram_exp);
			end
		end

		// Joystick merge output trails the inputs by one cycle
		for (int i = 0; i <= 64; i++) begin
			@(posedge CLK_VIDEO);
			rnd = next_rand();
			kbd_rows_i <= rnd[7:0];
			kbd_cols_i <= rnd[13:8];
			joy_i      <= joy_t'(rnd[19:14]);
			@(negedge CLK_VIDEO);
			if (i > 0)
				check_cols("kbd_cols_o", kbd_cols_o, merge_ref(prev_rows, prev_cols, prev_joy));
			prev_rows = rnd[7:0];
			prev_cols = rnd[13:8];
			prev_joy  = joy_t'(rnd[19:14]);
		end

		// Drive 1 with an empty image stays silent
		@(posedge CLK_VIDEO);
		img_mounted_i <= 2'b10;
		@(posedge CLK_VIDEO);
		img_mounted_i <= 2'b00;
		track_i[1]    <= track_num_t'(1 + next_rand() % 34);
		repeat (40) begin
			@(negedge CLK_VIDEO);
			check_sd_req("sd_req_o[1]", sd_req_o[1], '0);
			check_bit("cpu_wait_o", cpu_wait_o, 1'b0);
		end

		// Mount drive 0 and load a random track
		trk_a = track_num_t'(next_rand() % 35);
		host_log.delete();
		@(posedge CLK_VIDEO);
		img_size_i     <= 64'd143360;
		img_mounted_i  <= 2'b01;
		track_i[0]     <= trk_a;
		drive_active_i <= 2'b01;
		@(posedge CLK_VIDEO);
		img_mounted_i <= 2'b00;
		wait_track_load();
		check_log_size(SECTORS);
		expect_transfers(0, 1'b0, trk_a);
		repeat (32) begin
			sec = next_rand() % SECTORS;
			pos = next_rand() % 512;
			read_disk(sec, pos, img_byte(lba_t'(SECTORS * trk_a + sec), pos));
		end

		// Dirty track goes back to the image before the next one loads
		for (int i = 0; i < N_WRITES; i++) begin
			wr_sec[i] = next_rand() % SECTORS;
			wr_pos[i] = next_rand() % 512;
			wr_val[i] = byte_t'(next_rand());
			write_disk(wr_sec[i], wr_pos[i], wr_val[i]);
		end
		trk_b = track_num_t'((trk_a + 1 + next_rand() % 34) % 35);
		host_log.delete();
		@(posedge CLK_VIDEO);
		track_i[0] <= trk_b;
		wait_track_load();
		check_log_size(2 * SECTORS);
		expect_transfers(0, 1'b1, trk_a);
		expect_transfers(SECTORS, 1'b0, trk_b);
		for (int s = 0; s < SECTORS; s++)
			for (int p = 0; p < 512; p++)
				check_byte("captured write-back byte", cap_mem[s * 512 + p],
					written_track(trk_a, s, p));

		// Read mux, drive 0 priority and LED
		@(posedge CLK_VIDEO);
		drive_active_i <= 2'b00;
		@(negedge CLK_VIDEO);
		check_byte("fd_data_o", fd_data_o, 8'h00);
		for (int a = 0; a < 4; a++) begin
			@(posedge CLK_VIDEO);
			drive_active_i <= 2'(a);
			@(negedge CLK_VIDEO);
			check_bit("led_o", led_o, a != 0);
		end
		sec = next_rand() % SECTORS;
		pos = next_rand() % 512;
		val = byte_t'(next_rand());
		@(posedge CLK_VIDEO);
		drive_active_i <= 2'b10;
		write_disk(sec, pos, val);
		read_disk(sec, pos, val);
		@(posedge CLK_VIDEO);
		drive_active_i <= 2'b01;
		read_disk(sec, pos, img_byte(lba_t'(SECTORS * trk_b + sec), pos));
		@(posedge CLK_VIDEO);
		drive_active_i <= 2'b11;
		read_disk(sec, pos, img_byte(lba_t'(SECTORS * trk_b + sec), pos));

		if (drive1_reqs == 0) begin
			$display("Simulation finished: PASS");
			$finish;
		end else begin
			abort_run("drive 1 raised an SD request although it has no disk");
		end
	end

endmodule

`default_nettype wire

/* sources.f */
verilog/tk2000_pkg.sv
verilog/reset_sequencer.sv
verilog/joy_kbd_merge.sv
verilog/track_buffer.sv
verilog/track_loader.sv
verilog/floppy_subsystem.sv
verilog/tk2000_glue_top.sv
testbench/tb_tk2000_glue.sv

/* Makefile */
# Verilator build and run for the TK2000 glue testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_tk2000_glue
FILELIST  = sources.f
OBJ_DIR   = obj_dir
PASS_MSG  = Simulation finished: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The run fails unless the pass message shows up in the output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; status=$$?; echo "$$out"; \
	echo "$$out" | grep -q -F "$(PASS_MSG)" && [ $$status -eq 0 ]

clean:
	rm -rf $(OBJ_DIR)
